// ==== stall_top.f ====
stall_pkg.sv
mem_bus_if.sv
stall_lfsr.sv
stall_gnt_gate.sv
stall_rvalid_gate.sv
stall_mem.sv
stall_top.sv
tb_stall_top.sv

// ==== Makefile ====
# Verilator build and run of the stall injector testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_stall_top -f stall_top.f
	@out="$$(./obj_dir/Vtb_stall_top)"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// ==== stall_patterns.txt ====
// op: bit0 write, bit1 next access issued without waiting, bit2 write data from the LFSR
// op addr be wdata mode(0 off, 1 fixed, 2 random) gnt_stall rsp_stall max_stall
1 00000010 f 11223344 0 0 0 0
0 00000010 f 00000000 0 0 0 0
1 00000024 f a5a5a5a5 1 3 2 0
0 00000024 f 00000000 1 0 5 0
1 00000010 3 0000beef 1 2 0 0
1 00000010 c dead0000 1 0 3 0
1 00001010 4 00770000 1 1 1 0
0 00000010 f 00000000 1 4 4 0
5 00000030 f 00000000 2 0 0 7
5 00000034 9 00000000 2 0 0 7
0 00000030 f 00000000 2 0 0 7
7 00000040 f 00000000 1 0 3 0
7 00000044 f 00000000 1 0 3 0
7 00000048 f 00000000 1 0 3 0
7 0000004c f 00000000 1 0 3 0
7 00000050 f 00000000 1 0 3 0
2 00000040 f 00000000 1 0 3 0
2 00000044 f 00000000 1 0 3 0
2 00000048 f 00000000 1 0 3 0
2 0000004c f 00000000 1 0 3 0
0 00000050 f 00000000 1 0 3 0
6 00000060 f 00000000 2 0 0 9
6 00000064 f 00000000 2 0 0 9
2 00000060 f 00000000 2 0 0 9
0 00000064 f 00000000 2 0 0 9

// ==== tb_stall_top.sv ====
// Testbench for the load/store stall injector.
// Reads accesses from stall_patterns.txt, drives the core port on the falling
// edge, predicts read data with a byte enable memory model and checks grant
// and response latencies against the configured stalls.

`timescale 1ns/1ps

module tb_stall_top;

    // Granted access waiting for its response
    typedef struct {
        int                            num;
        logic                          we;
        logic [stall_pkg::ADDR_W-1:0]  addr;
        logic [stall_pkg::DATA_W-1:0]  data;
        int                            gnt_cyc;
        int                            gnt_lat;
        logic [stall_pkg::STALL_W-1:0] rsp_exp;
        logic                          exact;
        logic                          timed;
        logic                          gnt_ok;
    } pending_t;

    logic                          clk_i;
    logic                          rst_n_i;
    logic                          req_i;
    logic [stall_pkg::ADDR_W-1:0]  addr_i;
    logic                          we_i;
    logic [stall_pkg::BE_W-1:0]    be_i;
    logic [stall_pkg::DATA_W-1:0]  wdata_i;
    logic                          gnt_o;
    logic                          rvalid_o;
    logic [stall_pkg::DATA_W-1:0]  rdata_o;
    logic                          stall_en_i;
    stall_pkg::stall_mode_e        stall_mode_i;
    logic [stall_pkg::STALL_W-1:0] max_stall_i;
    logic [stall_pkg::STALL_W-1:0] gnt_stall_i;
    logic [stall_pkg::STALL_W-1:0] valid_stall_i;

    // Pattern columns
    logic [3:0]                    pat_op    [$];
    logic [stall_pkg::ADDR_W-1:0]  pat_addr  [$];
    logic [stall_pkg::BE_W-1:0]    pat_be    [$];
    logic [stall_pkg::DATA_W-1:0]  pat_wdata [$];
    logic [3:0]                    pat_mode  [$];
    logic [stall_pkg::STALL_W-1:0] pat_gnt   [$];
    logic [stall_pkg::STALL_W-1:0] pat_rsp   [$];
    logic [stall_pkg::STALL_W-1:0] pat_max   [$];

    logic [stall_pkg::DATA_W-1:0]  ref_mem [stall_pkg::MEM_WORDS];
    pending_t                      pending_q [$];
    logic [31:0]                   rnd_state = 32'd68813;
    int                            cyc = 0;
    int                            cycle_limit = 0;
    int                            err_cnt = 0;
    int                            n_pass = 0;
    int                            n_fail = 0;
    int                            unanswered = 0;

    stall_top DUT (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (req_i),
        .addr_i        (addr_i),
        .we_i          (we_i),
        .be_i          (be_i),
        .wdata_i       (wdata_i),
        .gnt_o         (gnt_o),
        .rvalid_o      (rvalid_o),
        .rdata_o       (rdata_o),
        .stall_en_i    (stall_en_i),
        .stall_mode_i  (stall_mode_i),
        .max_stall_i   (max_stall_i),
        .gnt_stall_i   (gnt_stall_i),
        .valid_stall_i (valid_stall_i)
    );

    // 4 ns period
    always #2 clk_i = ~clk_i;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Right shifting Galois LFSR, taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    // One LFSR step per data bit
    function automatic logic [stall_pkg::DATA_W-1:0] rand_word();
        logic [stall_pkg::DATA_W-1:0] w;
        for (int b = 0; b < stall_pkg::DATA_W; b++) begin
            w[b]      = rnd_state[0];
            rnd_state = lfsr_step(rnd_state);
        end
        return w;
    endfunction

    task automatic check_data(input logic [stall_pkg::DATA_W-1:0] got,
                              input logic [stall_pkg::DATA_W-1:0] exp, input int num);
        if (got !== exp) begin
            $display("** Error at %0t ns: access %0d read data %h, expected %h",
                     $time, num, got, exp);
            err_cnt++;
        end
    endtask

    // Exact in fixed or disabled mode, upper bound in random mode
    task automatic check_gnt_lat(input logic [stall_pkg::STALL_W-1:0] got,
                                 input logic [stall_pkg::STALL_W-1:0] exp,
                                 input logic exact, input int num);
        if (exact ? (got != exp) : (got > exp)) begin
            $display("** Error at %0t ns: access %0d grant latency %0d, expected %s%0d",
                     $time, num, got, exact ? "" : "at most ", exp);
            err_cnt++;
        end
    endtask

    task automatic check_rsp_lat(input logic [stall_pkg::STALL_W-1:0] got,
                                 input logic [stall_pkg::STALL_W-1:0] exp,
                                 input logic exact, input int num);
        if (exact ? (got != exp) : (got > exp)) begin
            $display("** Error at %0t ns: access %0d response latency %0d, expected %s%0d",
                     $time, num, got, exact ? "" : "at most ", exp);
            err_cnt++;
        end
    endtask

    // Lines that do not hold eight fields are skipped as comments
    task automatic load_patterns();
        int                            fd;
        int                            n;
        string                         line;
        logic [3:0]                    op;
        logic [3:0]                    mode;
        logic [stall_pkg::ADDR_W-1:0]  addr;
        logic [stall_pkg::BE_W-1:0]    be;
        logic [stall_pkg::DATA_W-1:0]  wd;
        logic [stall_pkg::STALL_W-1:0] gs;
        logic [stall_pkg::STALL_W-1:0] vs;
        logic [stall_pkg::STALL_W-1:0] mx;
        fd = $fopen("stall_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file stall_patterns.txt");
            err_cnt++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h %h", op, addr, be, wd, mode, gs, vs, mx);
            if (n == 8) begin
                pat_op.push_back(op);
                pat_addr.push_back(addr);
                pat_be.push_back(be);
                pat_wdata.push_back(wd);
                pat_mode.push_back(mode);
                pat_gnt.push_back(gs);
                pat_rsp.push_back(vs);
                pat_max.push_back(mx);
            end else begin
                void'($fgets(line, fd));
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////
    // Driver
    //////////////////////////////

    // Entered on a falling edge, returns on a falling edge
    task automatic run_access(input int i);
        pending_t                        e;
        int                              lat;
        int                              errs;
        logic [stall_pkg::DATA_W-1:0]    wd;
        logic [stall_pkg::MEM_IDX_W-1:0] idx;
        logic [stall_pkg::STALL_W-1:0]   gnt_exp;
        wd      = pat_op[i][2] ? rand_word() : pat_wdata[i];
        e.timed = (pending_q.size() == 0);
        req_i   = 1'b1;
        addr_i  = pat_addr[i];
        we_i    = pat_op[i][0];
        be_i    = pat_be[i];
        wdata_i = wd;
        stall_en_i    = (pat_mode[i] != 4'h0);
        stall_mode_i  = (pat_mode[i] == 4'h2) ? stall_pkg::RANDOM : stall_pkg::STANDARD;
        max_stall_i   = pat_max[i];
        gnt_stall_i   = pat_gnt[i];
        valid_stall_i = pat_rsp[i];
        // Expected stalls, exact unless drawn
        e.exact = (pat_mode[i] != 4'h2);
        case (pat_mode[i])
            4'h0: begin
                gnt_exp   = '0;
                e.rsp_exp = 4'd1;
            end
            4'h1: begin
                gnt_exp   = pat_gnt[i];
                e.rsp_exp = pat_rsp[i] + 1'b1;
            end
            default: begin
                gnt_exp   = pat_max[i];
                e.rsp_exp = pat_max[i] + 1'b1;
            end
        endcase
        lat = 0;
        @(posedge clk_i);
        while (!gnt_o) begin
            lat++;
            @(posedge clk_i);
        end
        // Old word goes back, then the write merges into the model
        idx    = pat_addr[i][stall_pkg::MEM_IDX_W+1:2];
        e.data = ref_mem[idx];
        if (pat_op[i][0]) begin
            for (int b = 0; b < stall_pkg::BE_W; b++) begin
                if (pat_be[i][b]) begin
                    ref_mem[idx][8*b +: 8] = wd[8*b +: 8];
                end
            end
        end
        errs = err_cnt;
        if (e.timed && lat >= (1 << stall_pkg::STALL_W)) begin
            $display("Access %0d waited %0d cycles for grant, far beyond any stall", i, lat);
            err_cnt++;
        end else if (e.timed) begin
            check_gnt_lat(stall_pkg::STALL_W'(lat), gnt_exp, e.exact, i);
        end
        e.num     = i;
        e.we      = pat_op[i][0];
        e.addr    = pat_addr[i];
        e.gnt_cyc = cyc;
        e.gnt_lat = lat;
        e.gnt_ok  = (err_cnt == errs);
        pending_q.push_back(e);
        @(negedge clk_i);
        req_i = 1'b0;
        // Single accesses wait for their response
        if (!pat_op[i][1]) begin
            while (pending_q.size() != 0) begin
                @(negedge clk_i);
            end
        end
    endtask

    //////////////////////////////
    // Response monitor
    //////////////////////////////

    always @(posedge clk_i) begin
        pending_t e;
        int       rsp_lat;
        int       errs;
        cyc <= cyc + 1;
        if (rst_n_i) begin
            // Unanswered grants seen at the ports
            if (gnt_o && req_i) begin
                unanswered++;
            end
            if (rvalid_o) begin
                unanswered--;
            end
            if (unanswered > stall_pkg::OUTSTANDING) begin
                $display("More than %0d grants unanswered at %0t ns",
                         stall_pkg::OUTSTANDING, $time);
                err_cnt++;
            end
            if (rvalid_o && pending_q.size() == 0) begin
                $display("Response at %0t ns with no granted access waiting", $time);
                err_cnt++;
            end else if (rvalid_o) begin
                e       = pending_q.pop_front();
                rsp_lat = cyc - e.gnt_cyc;
                errs    = err_cnt;
                check_data(rdata_o, e.data, e.num);
                if (e.timed && rsp_lat >= (1 << stall_pkg::STALL_W)) begin
                    $display("Access %0d response took %0d cycles after grant", e.num, rsp_lat);
                    err_cnt++;
                end else if (e.timed) begin
                    check_rsp_lat(stall_pkg::STALL_W'(rsp_lat), e.rsp_exp, e.exact, e.num);
                end
                if (err_cnt == errs && e.gnt_ok) begin
                    n_pass++;
                end else begin
                    n_fail++;
                end
                $display("access %2d %s addr %h data %h gnt %0d rsp %0d %s", e.num,
                         e.we ? "write" : "read ", e.addr, rdata_o, e.gnt_lat, rsp_lat,
                         (err_cnt == errs && e.gnt_ok) ? "ok" : "FAILED");
            end
        end
    end

    // Watchdog, limit set from the number of accesses
    initial begin
        @(posedge clk_i);
        while (cyc < cycle_limit) begin
            @(posedge clk_i);
        end
        $display("Timeout after %0d cycles, the run did not complete", cyc);
        $display("Simulation finished: FAIL");
        $finish;
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        req_i         = 1'b0;
        addr_i        = '0;
        we_i          = 1'b0;
        be_i          = '0;
        wdata_i       = '0;
        stall_en_i    = 1'b0;
        stall_mode_i  = stall_pkg::STANDARD;
        max_stall_i   = '0;
        gnt_stall_i   = '0;
        valid_stall_i = '0;
        // Memory comes out of reset cleared
        for (int w = 0; w < stall_pkg::MEM_WORDS; w++) begin
            ref_mem[w] = '0;
        end
        load_patterns();
        cycle_limit = pat_op.size() * (2 * 16 + 8) + stall_pkg::MEM_WORDS + 100;
        repeat (8) @(negedge clk_i);
        rst_n_i = 1'b1;
        // Memory clear runs MEM_WORDS cycles
        repeat (stall_pkg::MEM_WORDS + 2) @(negedge clk_i);
        for (int i = 0; i < pat_op.size(); i++) begin
            run_access(i);
        end
        while (pending_q.size() != 0) begin
            @(negedge clk_i);
        end
        // Idle tail to catch stray responses
        repeat (4) @(negedge clk_i);
        $display("accesses %0d, passed %0d, failed %0d, errors %0d",
                 pat_op.size(), n_pass, n_fail, err_cnt);
        if (err_cnt == 0 && pat_op.size() > 0 && n_pass == pat_op.size()) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== stall_top.sv ====
// Stall injector top level for a load/store port.
// Sits between the core and a memory model and delays grants and
// responses by fixed or random counts. Plain ports only.

`timescale 1ns/1ps

module stall_top (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    // Core load/store port
    input  logic                          req_i,
    input  logic [stall_pkg::ADDR_W-1:0]  addr_i,
    input  logic                          we_i,
    input  logic [stall_pkg::BE_W-1:0]    be_i,
    input  logic [stall_pkg::DATA_W-1:0]  wdata_i,
    output logic                          gnt_o,
    output logic                          rvalid_o,
    output logic [stall_pkg::DATA_W-1:0]  rdata_o,
    // Stall configuration
    input  logic                          stall_en_i,
    input  stall_pkg::stall_mode_e        stall_mode_i,
    input  logic [stall_pkg::STALL_W-1:0] max_stall_i,
    input  logic [stall_pkg::STALL_W-1:0] gnt_stall_i,
    input  logic [stall_pkg::STALL_W-1:0] valid_stall_i
);

    logic                          gnt_draw;
    logic                          rsp_draw;
    logic [stall_pkg::STALL_W-1:0] gnt_rnd;
    logic [stall_pkg::STALL_W-1:0] rsp_rnd;

    // Grant gate to memory
    mem_bus_if core_bus ();

    //////////////////////////////
    // Random stall sources
    //////////////////////////////

    stall_lfsr #(
        .SEED (stall_pkg::LFSR_SEED_GNT)
    ) u_gnt_lfsr (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .draw_i  (gnt_draw),
        .max_i   (max_stall_i),
        .count_o (gnt_rnd)
    );

    stall_lfsr #(
        .SEED (stall_pkg::LFSR_SEED_RSP)
    ) u_rsp_lfsr (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .draw_i  (rsp_draw),
        .max_i   (max_stall_i),
        .count_o (rsp_rnd)
    );

    //////////////////////////////
    // Request and response paths
    //////////////////////////////

    // Each delivered response frees one outstanding slot
    stall_gnt_gate u_gnt_gate (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (req_i),
        .addr_i       (addr_i),
        .we_i         (we_i),
        .be_i         (be_i),
        .wdata_i      (wdata_i),
        .gnt_o        (gnt_o),
        .stall_en_i   (stall_en_i),
        .stall_mode_i (stall_mode_i),
        .gnt_stall_i  (gnt_stall_i),
        .rnd_count_i  (gnt_rnd),
        .draw_o       (gnt_draw),
        .rsp_done_i   (rvalid_o),
        .mem          (core_bus.core)
    );

    stall_mem u_mem (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus     (core_bus.mem)
    );

    // Memory responses leave the bus on plain wires
    stall_rvalid_gate u_rvalid_gate (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .mem_rvalid_i  (core_bus.rvalid),
        .mem_rdata_i   (core_bus.rdata),
        .stall_en_i    (stall_en_i),
        .stall_mode_i  (stall_mode_i),
        .valid_stall_i (valid_stall_i),
        .rnd_count_i   (rsp_rnd),
        .draw_o        (rsp_draw),
        .rvalid_o      (rvalid_o),
        .rdata_o       (rdata_o)
    );

endmodule

// ==== stall_mem.sv ====
// Word addressed data memory model with byte enabled writes.
// Grants a request in its own cycle and answers one cycle later.
// After reset it spends MEM_WORDS cycles clearing itself, without grants.

`timescale 1ns/1ps

module stall_mem (
    input  logic   clk_i,
    input  logic   rst_n_i,
    mem_bus_if.mem bus
);

    logic [stall_pkg::DATA_W-1:0]    mem_q [stall_pkg::MEM_WORDS];
    logic                            init_q;
    logic [stall_pkg::MEM_IDX_W-1:0] init_idx_q;
    logic [stall_pkg::MEM_IDX_W-1:0] idx;
    logic                            rvalid_q;
    logic [stall_pkg::DATA_W-1:0]    rdata_q;

    // Upper address bits beyond the array and the byte offset are ignored
    assign idx = bus.addr[stall_pkg::MEM_IDX_W+1:2];

    // No grants while clearing
    assign bus.gnt = bus.req && !init_q;

    // Clear sequencer
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            init_q     <= 1'b1;
            init_idx_q <= '0;
        end else if (init_q) begin
            init_idx_q <= init_idx_q + 1'b1;
            if (init_idx_q == stall_pkg::MEM_IDX_W'(stall_pkg::MEM_WORDS - 1)) begin
                init_q <= 1'b0;
            end
        end
    end

    // Storage, cleared word by word, then written by byte enable
    always_ff @(posedge clk_i) begin
        if (init_q) begin
            mem_q[init_idx_q] <= '0;
        end else if (bus.gnt && bus.we) begin
            for (int b = 0; b < stall_pkg::BE_W; b++) begin
                if (bus.be[b]) begin
                    mem_q[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // Response one cycle after grant
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus.gnt;
        end
    end

    // Old word for writes, stored word for reads
    always_ff @(posedge clk_i) begin
        if (bus.gnt) begin
            rdata_q <= mem_q[idx];
        end
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;

endmodule

// ==== stall_rvalid_gate.sv ====
// Response stall gate between the memory and the core.
// Responses are queued with their own stall count and leave in order,
// each after waiting its count once it is at the head.

`timescale 1ns/1ps

module stall_rvalid_gate (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    // Memory responses
    input  logic                          mem_rvalid_i,
    input  logic [stall_pkg::DATA_W-1:0]  mem_rdata_i,
    // Stall configuration
    input  logic                          stall_en_i,
    input  stall_pkg::stall_mode_e        stall_mode_i,
    input  logic [stall_pkg::STALL_W-1:0] valid_stall_i,
    input  logic [stall_pkg::STALL_W-1:0] rnd_count_i,
    output logic                          draw_o,
    // Core responses
    output logic                          rvalid_o,
    output logic [stall_pkg::DATA_W-1:0]  rdata_o
);

    // Queue storage, payload only
    logic [stall_pkg::DATA_W-1:0]  data_q  [stall_pkg::OUTSTANDING];
    logic [stall_pkg::STALL_W-1:0] stall_q [stall_pkg::OUTSTANDING];

    logic [stall_pkg::OUT_PTR_W-1:0] wr_ptr_q;
    logic [stall_pkg::OUT_PTR_W-1:0] rd_ptr_q;
    logic [stall_pkg::OUT_CNT_W-1:0] count_q;

    logic                            empty;
    logic                            full;
    logic [stall_pkg::STALL_W-1:0]   in_stall;
    logic                            head_valid;
    logic [stall_pkg::STALL_W-1:0]   head_stall;
    logic                            hold_q;
    logic [stall_pkg::STALL_W-1:0]   wait_q;
    logic [stall_pkg::STALL_W-1:0]   cur_wait;
    logic                            push;
    logic                            pop;

    assign empty = (count_q == '0);
    assign full  = (count_q == stall_pkg::OUT_CNT_W'(stall_pkg::OUTSTANDING));

    // Stall for the response arriving now
    always_comb begin
        if (!stall_en_i) begin
            in_stall = '0;
        end else if (stall_mode_i == stall_pkg::RANDOM) begin
            in_stall = rnd_count_i;
        end else begin
            in_stall = valid_stall_i;
        end
    end

    assign draw_o = mem_rvalid_i && stall_en_i && (stall_mode_i == stall_pkg::RANDOM);

    //////////////////////////////
    // Head of queue
    //////////////////////////////

    // An empty queue lets the arriving response act as head
    assign head_valid = !empty || mem_rvalid_i;
    assign head_stall = empty ? in_stall : stall_q[rd_ptr_q];
    assign rdata_o    = empty ? mem_rdata_i : data_q[rd_ptr_q];

    // Counter is loaded the first cycle an entry sits at the head
    assign cur_wait = hold_q ? wait_q : head_stall;
    assign rvalid_o = head_valid && (cur_wait == '0);

    // Zero stall on an empty queue bypasses storage entirely
    assign push = mem_rvalid_i && !(empty && rvalid_o);
    assign pop  = rvalid_o && !empty;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hold_q <= 1'b0;
            wait_q <= '0;
        end else if (rvalid_o || !head_valid) begin
            hold_q <= 1'b0;
            wait_q <= '0;
        end else begin
            hold_q <= 1'b1;
            wait_q <= cur_wait - 1'b1;
        end
    end

    //////////////////////////////
    // Circular queue
    //////////////////////////////

    always_ff @(posedge clk_i) begin
        if (push) begin
            data_q[wr_ptr_q]  <= mem_rdata_i;
            stall_q[wr_ptr_q] <= in_stall;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == stall_pkg::OUT_PTR_W'(stall_pkg::OUTSTANDING - 1))
                            ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == stall_pkg::OUT_PTR_W'(stall_pkg::OUTSTANDING - 1))
                            ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Grant gate limit keeps the queue from ever overflowing
    a_no_push_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        push |-> !full || pop
    );

endmodule

// ==== stall_gnt_gate.sv ====
// Grant stall gate between the core request port and the memory.
// Each new request is held off for the selected stall count before it
// is forwarded. Grants also stop while OUTSTANDING responses are pending.

`timescale 1ns/1ps

module stall_gnt_gate (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    // Core side
    input  logic                          req_i,
    input  logic [stall_pkg::ADDR_W-1:0]  addr_i,
    input  logic                          we_i,
    input  logic [stall_pkg::BE_W-1:0]    be_i,
    input  logic [stall_pkg::DATA_W-1:0]  wdata_i,
    output logic                          gnt_o,
    // Stall configuration
    input  logic                          stall_en_i,
    input  stall_pkg::stall_mode_e        stall_mode_i,
    input  logic [stall_pkg::STALL_W-1:0] gnt_stall_i,
    input  logic [stall_pkg::STALL_W-1:0] rnd_count_i,
    output logic                          draw_o,
    // One pulse per response delivered to the core
    input  logic                          rsp_done_i,
    // Memory side
    mem_bus_if.core                       mem
);

    logic                            busy_q;
    logic [stall_pkg::STALL_W-1:0]   cnt_q;
    logic [stall_pkg::STALL_W-1:0]   sel_stall;
    logic [stall_pkg::STALL_W-1:0]   cur_cnt;
    logic [stall_pkg::OUT_CNT_W-1:0] outst_q;
    logic                            new_req;
    logic                            full;

    //////////////////////////////
    // Stall count
    //////////////////////////////

    // First cycle of a request not yet being counted
    assign new_req = req_i && !busy_q;

    // Zero when disabled, else fixed or drawn
    always_comb begin
        if (!stall_en_i) begin
            sel_stall = '0;
        end else if (stall_mode_i == stall_pkg::RANDOM) begin
            sel_stall = rnd_count_i;
        end else begin
            sel_stall = gnt_stall_i;
        end
    end

    // Draw only when the drawn value is actually used
    assign draw_o = new_req && stall_en_i && (stall_mode_i == stall_pkg::RANDOM);

    // Freshly selected count on the first cycle, running count after
    assign cur_cnt = busy_q ? cnt_q : sel_stall;

    // Back-pressure
    assign full = (outst_q == stall_pkg::OUT_CNT_W'(stall_pkg::OUTSTANDING));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (gnt_o || !req_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            busy_q <= 1'b1;
            // Count held while the outstanding limit is reached
            if (cur_cnt != '0 && !full) begin
                cnt_q <= cur_cnt - 1'b1;
            end else begin
                cnt_q <= cur_cnt;
            end
        end
    end

    //////////////////////////////
    // Forward to memory
    //////////////////////////////

    assign mem.req   = req_i && (cur_cnt == '0) && !full;
    assign mem.addr  = addr_i;
    assign mem.we    = we_i;
    assign mem.be    = be_i;
    assign mem.wdata = wdata_i;

    // Memory only grants a forwarded request
    assign gnt_o = mem.gnt;

    // Granted requests waiting for their response
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            outst_q <= '0;
        end else begin
            case ({gnt_o, rsp_done_i})
                2'b10:   outst_q <= outst_q + 1'b1;
                2'b01:   outst_q <= outst_q - 1'b1;
                default: outst_q <= outst_q;
            endcase
        end
    end

    // Core keeps the request fields steady until it sees grant
    a_req_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        req_i && !gnt_o |=> req_i && $stable({addr_i, we_i, be_i, wdata_i})
    );

    // Response path never falls behind the grant limit
    a_outst_limit: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        outst_q <= stall_pkg::OUT_CNT_W'(stall_pkg::OUTSTANDING)
    );

endmodule

// ==== stall_lfsr.sv ====
// Galois LFSR that supplies random stall counts.
// The state advances on each draw strobe. The count is clamped to max_i.

`timescale 1ns/1ps

module stall_lfsr #(
    parameter logic [stall_pkg::LFSR_W-1:0] SEED = stall_pkg::LFSR_SEED_GNT
) (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         draw_i,
    input  logic [stall_pkg::STALL_W-1:0] max_i,
    output logic [stall_pkg::STALL_W-1:0] count_o
);

    logic [stall_pkg::LFSR_W-1:0]  state_q;
    logic [stall_pkg::STALL_W-1:0] raw;

    // Shift right, fold taps in when the bit shifted out is set
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= SEED;
        end else if (draw_i) begin
            if (state_q[0]) begin
                state_q <= (state_q >> 1) ^ stall_pkg::LFSR_TAPS;
            end else begin
                state_q <= state_q >> 1;
            end
        end
    end

    // Low bits of the state, never above the configured maximum
    assign raw     = state_q[stall_pkg::STALL_W-1:0];
    assign count_o = (raw > max_i) ? max_i : raw;

    // A zero state would lock the sequence at zero for good
    a_state_nonzero: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        draw_i |=> state_q != '0
    );

endmodule

// ==== mem_bus_if.sv ====
// One request/grant/response memory port.
// The core modport issues requests, the mem modport grants and answers.

`timescale 1ns/1ps

interface mem_bus_if;

    // Request side, held stable until gnt
    logic                          req;
    logic [stall_pkg::ADDR_W-1:0]  addr;
    logic                          we;
    logic [stall_pkg::BE_W-1:0]    be;
    logic [stall_pkg::DATA_W-1:0]  wdata;

    // Grant, same cycle as an accepted request
    logic                          gnt;

    // Response, exactly one per grant, in grant order
    logic                          rvalid;
    logic [stall_pkg::DATA_W-1:0]  rdata;

    modport core (
        output req,
        output addr,
        output we,
        output be,
        output wdata,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport mem (
        input  req,
        input  addr,
        input  we,
        input  be,
        input  wdata,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

// ==== stall_pkg.sv ====
// Shared widths, depths, LFSR constants and the stall mode type
// for the load/store stall injector. Design files refer to these
// through scoped names.

package stall_pkg;

    //////////////////////////////
    // Bus widths
    //////////////////////////////

    // Byte address, data word and byte enables
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;

    // Every stall count and the configured maximum
    localparam int STALL_W = 4;

    //////////////////////////////
    // Depths
    //////////////////////////////

    // Memory model, word addressed
    localparam int MEM_WORDS = 64;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    // Granted but unanswered requests, also the response queue depth
    localparam int OUTSTANDING = 4;
    localparam int OUT_PTR_W   = $clog2(OUTSTANDING);
    localparam int OUT_CNT_W   = $clog2(OUTSTANDING + 1);

    //////////////////////////////
    // LFSR
    //////////////////////////////

    // Galois form of x^16 + x^14 + x^13 + x^11 + 1
    localparam int              LFSR_W        = 16;
    localparam logic [LFSR_W-1:0] LFSR_TAPS     = 16'hB400;
    // Distinct seeds so grant and response stalls do not track each other
    localparam logic [LFSR_W-1:0] LFSR_SEED_GNT = 16'hACE1;
    localparam logic [LFSR_W-1:0] LFSR_SEED_RSP = 16'h1D2B;

    // Fixed counts from configuration, or LFSR draws up to the maximum
    typedef enum logic {
        STANDARD = 1'b0,
        RANDOM   = 1'b1
    } stall_mode_e;

endpackage
